// File: axi_rd_pkg.sv
// Shared AXI read encodings; only OKAY and SLVERR are ever produced by this subordinate
package axi_rd_pkg;

    // ----------------------------------------------------------------------
    // AXI field widths
    // ----------------------------------------------------------------------

    // Burst length field, beats minus one
    localparam int AXI_LEN_W  = 8;
    // Burst size field, log2 of bytes per beat
    localparam int AXI_SIZE_W = 3;

    // ----------------------------------------------------------------------
    // Encodings
    // ----------------------------------------------------------------------

    // AxBURST
    typedef enum logic [1:0] {
        AXI_BURST_FIXED    = 2'b00,
        AXI_BURST_INCR     = 2'b01,
        AXI_BURST_WRAP     = 2'b10,
        AXI_BURST_RESERVED = 2'b11
    } axi_burst_e;

    // xRESP
    // EXOKAY and DECERR kept for completeness of the encoding
    typedef enum logic [1:0] {
        AXI_RESP_OKAY   = 2'b00,
        AXI_RESP_EXOKAY = 2'b01,
        AXI_RESP_SLVERR = 2'b10,
        AXI_RESP_DECERR = 2'b11
    } axi_resp_e;

endpackage

// File: axi_rd_addr_gen.sv
// Combinational next-beat address; WRAP assumes a legal len of 1, 3, 7 or 15, size is capped at DW
module axi_rd_addr_gen #(
    parameter int AW = 32,
    parameter int DW = 32
) (
    input  logic [AW-1:0]                     i_last_addr,
    input  logic [axi_rd_pkg::AXI_SIZE_W-1:0] i_size,
    input  axi_rd_pkg::axi_burst_e            i_burst,
    input  logic [axi_rd_pkg::AXI_LEN_W-1:0]  i_len,
    output logic [AW-1:0]                     o_next_addr
);

    // Byte lane bits of one data word
    localparam int BW = $clog2(DW / 8);

    logic [axi_rd_pkg::AXI_SIZE_W-1:0] size_eff;
    logic [AW-1:0]                     incr;
    logic [AW-1:0]                     wrap_bytes;
    logic [AW-1:0]                     wrap_mask;
    logic [AW-1:0]                     addr_incr;

    // ----------------------------------------------------------------------
    // Beat increment and wrap window
    // ----------------------------------------------------------------------

    // Beats wider than the bus are not legal, clamp to the bus width
    always_comb begin
        if (i_size > axi_rd_pkg::AXI_SIZE_W'(BW)) begin
            size_eff = axi_rd_pkg::AXI_SIZE_W'(BW);
        end else begin
            size_eff = i_size;
        end
    end

    assign incr       = AW'(1) << size_eff;
    // Total bytes of the burst, a power of two for WRAP
    assign wrap_bytes = incr * (AW'(i_len) + AW'(1));
    assign wrap_mask  = wrap_bytes - AW'(1);
    assign addr_incr  = i_last_addr + incr;

    // ----------------------------------------------------------------------
    // Next address select
    // ----------------------------------------------------------------------
    always_comb begin
        case (i_burst)
            axi_rd_pkg::AXI_BURST_INCR: begin
                o_next_addr = addr_incr;
            end
            axi_rd_pkg::AXI_BURST_WRAP: begin
                // Upper bits stay put, only the window offset rolls over
                o_next_addr = (i_last_addr & ~wrap_mask) | (addr_incr & wrap_mask);
            end
            // FIXED and the reserved code both hold the address
            default: begin
                o_next_addr = i_last_addr;
            end
        endcase
    end

endmodule

// File: axi_rd_burst_ctrl.sv
// Burst control; one burst active at a time, a new AR is taken on the final component beat
module axi_rd_burst_ctrl #(
    parameter int AW = 32,
    parameter int IW = 2
) (
    input  logic                              clk,
    input  logic                              rst_n,
    // AR channel
    input  logic                              i_arvalid,
    output logic                              o_arready,
    input  logic [AW-1:0]                     i_araddr,
    input  axi_rd_pkg::axi_burst_e            i_arburst,
    input  logic [axi_rd_pkg::AXI_SIZE_W-1:0] i_arsize,
    input  logic [axi_rd_pkg::AXI_LEN_W-1:0]  i_arlen,
    input  logic [IW-1:0]                     i_arid,
    // Burst context to the address generator
    output logic [AW-1:0]                     o_cur_addr,
    output logic [axi_rd_pkg::AXI_SIZE_W-1:0] o_cur_size,
    output axi_rd_pkg::axi_burst_e            o_cur_burst,
    output logic [axi_rd_pkg::AXI_LEN_W-1:0]  o_cur_len,
    input  logic [AW-1:0]                     i_next_addr,
    // Component request side
    output logic                              o_dv,
    input  logic                              i_hld,
    input  logic                              i_pipe_ready,
    output logic                              o_req_fire,
    output logic [IW-1:0]                     o_req_id,
    output logic                              o_req_last
);

    logic                             active;
    logic [axi_rd_pkg::AXI_LEN_W-1:0] beat_cnt;
    logic                             ar_fire;
    logic                             final_beat;

    // ----------------------------------------------------------------------
    // Handshakes
    // ----------------------------------------------------------------------
    assign ar_fire    = i_arvalid && o_arready;
    // Request goes out only when the response pipe can hold it under full stall
    assign o_dv       = active && i_pipe_ready;
    assign o_req_fire = o_dv && !i_hld;
    assign o_req_last = (beat_cnt == '0);
    assign final_beat = o_req_fire && o_req_last;
    // Next burst may overlap the final request beat
    assign o_arready  = !active || final_beat;

    // ----------------------------------------------------------------------
    // Active flag and beat counter
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active   <= 1'b0;
            beat_cnt <= '0;
        end else if (ar_fire) begin
            active   <= 1'b1;
            beat_cnt <= i_arlen;
        end else if (o_req_fire) begin
            // Drops after the beat that carries last
            active   <= !o_req_last;
            // Saturate at zero
            if (beat_cnt != '0) begin
                beat_cnt <= beat_cnt - 1'b1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Burst context
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            o_cur_addr  <= i_araddr;
            o_cur_burst <= i_arburst;
            o_cur_size  <= i_arsize;
            o_cur_len   <= i_arlen;
            o_req_id    <= i_arid;
        end else if (o_req_fire) begin
            // Only the address moves within a burst
            o_cur_addr <= i_next_addr;
        end
    end

endmodule

// File: axi_rd_ctx_pipe.sv
// Request context delay of exactly C_LAT cycles; C_LAT of zero is a plain pass-through
module axi_rd_ctx_pipe #(
    parameter int IW    = 2,
    parameter int C_LAT = 2
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          i_valid,
    input  logic [IW-1:0] i_id,
    input  logic          i_last,
    output logic          o_valid,
    output logic [IW-1:0] o_id,
    output logic          o_last
);

    if (C_LAT == 0) begin : g_pass
        // Component answers in the same cycle
        assign o_valid = i_valid;
        assign o_id    = i_id;
        assign o_last  = i_last;
    end else begin : g_shift
        logic [C_LAT-1:0] vld_sr;
        logic [C_LAT-1:0] last_sr;
        logic [IW-1:0]    id_sr [C_LAT];

        // Valid bits form the control path
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                vld_sr <= '0;
            end else begin
                vld_sr[0] <= i_valid;
                for (int i = 1; i < C_LAT; i++) begin
                    vld_sr[i] <= vld_sr[i-1];
                end
            end
        end

        // ID and last ride along
        always_ff @(posedge clk) begin
            id_sr[0]   <= i_id;
            last_sr[0] <= i_last;
            for (int i = 1; i < C_LAT; i++) begin
                id_sr[i]   <= id_sr[i-1];
                last_sr[i] <= last_sr[i-1];
            end
        end

        assign o_valid = vld_sr[C_LAT-1];
        assign o_id    = id_sr[C_LAT-1];
        assign o_last  = last_sr[C_LAT-1];
    end

endmodule

// File: axi_rd_skid_buf.sv
// Skid stage; o_ready comes from a register only, so it never depends on i_ready in the same cycle
module axi_rd_skid_buf #(
    parameter int PW = 32
) (
    input  logic          clk,
    input  logic          rst_n,
    // Upstream
    input  logic          i_valid,
    output logic          o_ready,
    input  logic [PW-1:0] i_data,
    // Downstream
    output logic          o_valid,
    input  logic          i_ready,
    output logic [PW-1:0] o_data
);

    // Holding entry, used only while downstream stalls
    logic          hold_vld;
    logic [PW-1:0] hold_data;

    // ----------------------------------------------------------------------
    // Holding entry control
    // ----------------------------------------------------------------------

    // Fills when a beat arrives and downstream stalls
    // Empties as soon as downstream takes it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_vld <= 1'b0;
        end else if (i_ready) begin
            hold_vld <= 1'b0;
        end else if (i_valid && !hold_vld) begin
            hold_vld <= 1'b1;
        end
    end

    // Captured on every upstream transfer, harmless if it passes straight on
    always_ff @(posedge clk) begin
        if (i_valid && !hold_vld) begin
            hold_data <= i_data;
        end
    end

    // ----------------------------------------------------------------------
    // Outputs
    // ----------------------------------------------------------------------
    assign o_ready = !hold_vld;
    assign o_valid = i_valid || hold_vld;
    // Held beat is older, it goes first
    assign o_data  = hold_vld ? hold_data : i_data;

endmodule

// File: axi_rd_resp_pipe.sv
// Response path of C_LAT+1 skid stages; the input has no ready, callers must gate on o_all_ready
module axi_rd_resp_pipe #(
    parameter int DW    = 32,
    parameter int IW    = 2,
    parameter int C_LAT = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // From component and context pipe
    input  logic                  i_valid,
    input  logic [DW-1:0]         i_rdata,
    input  logic                  i_err,
    input  logic [IW-1:0]         i_id,
    input  logic                  i_last,
    output logic                  o_all_ready,
    // R channel
    input  logic                  i_rready,
    output logic                  o_rvalid,
    output logic [DW-1:0]         o_rdata,
    output axi_rd_pkg::axi_resp_e o_rresp,
    output logic [IW-1:0]         o_rid,
    output logic                  o_rlast
);

    // Payload is {data, id, last, resp}
    localparam int PW = DW + IW + 1 + 2;
    localparam int NS = C_LAT + 1;

    axi_rd_pkg::axi_resp_e   resp_in;
    logic [1:0]              resp_out;
    logic [NS:0]             stg_vld;
    logic [NS:0]             stg_rdy;
    logic [NS:0][PW-1:0]     stg_pld;

    // ----------------------------------------------------------------------
    // Stage 0 payload
    // ----------------------------------------------------------------------
    assign resp_in    = i_err ? axi_rd_pkg::AXI_RESP_SLVERR : axi_rd_pkg::AXI_RESP_OKAY;
    assign stg_vld[0] = i_valid;
    assign stg_pld[0] = {i_rdata, i_id, i_last, resp_in};

    // ----------------------------------------------------------------------
    // Skid chain
    // ----------------------------------------------------------------------
    for (genvar s = 0; s < NS; s++) begin : g_stage
        axi_rd_skid_buf #(
            .PW (PW)
        ) u_skid (
            .clk     (clk),
            .rst_n   (rst_n),
            .i_valid (stg_vld[s]),
            .o_ready (stg_rdy[s]),
            .i_data  (stg_pld[s]),
            .o_valid (stg_vld[s+1]),
            .i_ready (stg_rdy[s+1]),
            .o_data  (stg_pld[s+1])
        );
    end

    // Last stage is stalled directly by the R channel
    assign stg_rdy[NS] = i_rready;

    // All stages empty means room for every beat still in flight
    assign o_all_ready = &stg_rdy[NS-1:0];

    // ----------------------------------------------------------------------
    // R channel
    // ----------------------------------------------------------------------
    assign o_rvalid = stg_vld[NS];
    assign {o_rdata, o_rid, o_rlast, resp_out} = stg_pld[NS];
    assign o_rresp  = axi_rd_pkg::axi_resp_e'(resp_out);

endmodule

// File: axi_rd_sub.sv
// AXI read subordinate top; responses leave in request order, DW must be at least 16 bits
module axi_rd_sub #(
    parameter int AW    = 32,
    parameter int DW    = 32,
    parameter int IW    = 2,
    parameter int C_LAT = 2
) (
    input  logic                              clk,
    input  logic                              rst_n,
    // AR channel
    input  logic                              i_arvalid,
    output logic                              o_arready,
    input  logic [AW-1:0]                     i_araddr,
    input  logic [1:0]                        i_arburst,
    input  logic [axi_rd_pkg::AXI_SIZE_W-1:0] i_arsize,
    input  logic [axi_rd_pkg::AXI_LEN_W-1:0]  i_arlen,
    input  logic [IW-1:0]                     i_arid,
    // R channel
    output logic                              o_rvalid,
    input  logic                              i_rready,
    output logic [DW-1:0]                     o_rdata,
    output logic [1:0]                        o_rresp,
    output logic [IW-1:0]                     o_rid,
    output logic                              o_rlast,
    // Component side
    output logic                              o_dv,
    output logic [AW-1:0]                     o_addr,
    output logic [IW-1:0]                     o_id,
    output logic                              o_last,
    input  logic                              i_hld,
    input  logic                              i_err,
    input  logic [DW-1:0]                     i_rdata
);

    localparam int BW = $clog2(DW / 8);

    logic [AW-1:0]                     cur_addr;
    logic [AW-1:0]                     next_addr;
    logic [axi_rd_pkg::AXI_SIZE_W-1:0] cur_size;
    axi_rd_pkg::axi_burst_e            cur_burst;
    logic [axi_rd_pkg::AXI_LEN_W-1:0]  cur_len;
    logic                              req_fire;
    logic                              pipe_ready;
    logic                              ctx_valid;
    logic [IW-1:0]                     ctx_id;
    logic                              ctx_last;

    // ----------------------------------------------------------------------
    // Control
    // ----------------------------------------------------------------------
    axi_rd_burst_ctrl #(
        .AW (AW),
        .IW (IW)
    ) u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_arvalid    (i_arvalid),
        .o_arready    (o_arready),
        .i_araddr     (i_araddr),
        .i_arburst    (axi_rd_pkg::axi_burst_e'(i_arburst)),
        .i_arsize     (i_arsize),
        .i_arlen      (i_arlen),
        .i_arid       (i_arid),
        .o_cur_addr   (cur_addr),
        .o_cur_size   (cur_size),
        .o_cur_burst  (cur_burst),
        .o_cur_len    (cur_len),
        .i_next_addr  (next_addr),
        .o_dv         (o_dv),
        .i_hld        (i_hld),
        .i_pipe_ready (pipe_ready),
        .o_req_fire   (req_fire),
        .o_req_id     (o_id),
        .o_req_last   (o_last)
    );

    // Full byte address in, so sub-word bursts step correctly
    axi_rd_addr_gen #(
        .AW (AW),
        .DW (DW)
    ) u_addr_gen (
        .i_last_addr (cur_addr),
        .i_size      (cur_size),
        .i_burst     (cur_burst),
        .i_len       (cur_len),
        .o_next_addr (next_addr)
    );

    // Component sees word-aligned addresses
    assign o_addr = {cur_addr[AW-1:BW], BW'(0)};

    // ----------------------------------------------------------------------
    // Datapath
    // ----------------------------------------------------------------------
    axi_rd_ctx_pipe #(
        .IW    (IW),
        .C_LAT (C_LAT)
    ) u_ctx_pipe (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_valid (req_fire),
        .i_id    (o_id),
        .i_last  (o_last),
        .o_valid (ctx_valid),
        .o_id    (ctx_id),
        .o_last  (ctx_last)
    );

    axi_rd_resp_pipe #(
        .DW    (DW),
        .IW    (IW),
        .C_LAT (C_LAT)
    ) u_resp_pipe (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_valid     (ctx_valid),
        .i_rdata     (i_rdata),
        .i_err       (i_err),
        .i_id        (ctx_id),
        .i_last      (ctx_last),
        .o_all_ready (pipe_ready),
        .i_rready    (i_rready),
        .o_rvalid    (o_rvalid),
        .o_rdata     (o_rdata),
        .o_rresp     (o_rresp),
        .o_rid       (o_rid),
        .o_rlast     (o_rlast)
    );

endmodule

// File: tb_axi_rd_checker.sv
// R channel and component request checker; bursts must be queued in AR order, DW of 32 only
module tb_axi_rd_checker #(
    parameter int AW = 32,
    parameter int DW = 32,
    parameter int IW = 2
) (
    input logic          clk,
    input logic          rst_n,
    input logic          i_arready,
    input logic          i_dv,
    input logic          i_hld,
    input logic [AW-1:0] i_addr,
    input logic [IW-1:0] i_id,
    input logic          i_last,
    input logic          i_rvalid,
    input logic          i_rready,
    input logic [DW-1:0] i_rdata,
    input logic [1:0]    i_rresp,
    input logic [IW-1:0] i_rid,
    input logic          i_rlast
);

    // Expected bursts, oldest first
    string         q_name  [$];
    logic [IW-1:0] q_id    [$];
    int            q_len   [$];
    int            q_size  [$];
    int            q_burst [$];
    logic [AW-1:0] q_addr  [$];
    logic [AW-1:0] q_final [$];

    int            err_cnt    = 0;
    int            beat_cnt   = 0;
    int            burst_cnt  = 0;
    int            beat_idx   = 0;
    logic [AW-1:0] cur_addr   = '0;
    logic          reset_seen = 1'b0;
    // Request side runs ahead of the R channel, index into the queues above
    int            req_q_idx  = 0;
    int            req_beat   = 0;
    logic [AW-1:0] req_addr   = '0;

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------

    // Called from the testbench top when a burst goes out on AR
    task automatic add_burst(input string name, input logic [IW-1:0] id, input int len,
                             input int size, input int burst, input logic [AW-1:0] addr,
                             input logic [AW-1:0] fin);
        q_name.push_back(name);
        q_id.push_back(id);
        q_len.push_back(len);
        q_size.push_back(size);
        q_burst.push_back(burst);
        q_addr.push_back(addr);
        q_final.push_back(fin);
    endtask

    // Next beat address, WRAP folds back once it leaves the aligned window
    function automatic logic [AW-1:0] step_addr(input logic [AW-1:0] addr, input int size,
                                                input int burst, input int len);
        logic [AW-1:0] incr;
        logic [AW-1:0] total;
        logic [AW-1:0] base;
        logic [AW-1:0] nxt;
        incr  = AW'(1) << size;
        total = incr * (AW'(len) + AW'(1));
        nxt   = addr + incr;
        if (burst == 0) begin
            nxt = addr;
        end else if (burst == 2) begin
            base = (addr / total) * total;
            if (nxt >= base + total) begin
                nxt = nxt - total;
            end
        end
        return nxt;
    endfunction

    task automatic check_value(input string test, input string what,
                               input logic [DW-1:0] exp, input logic [DW-1:0] act);
        if (exp != act) begin
            $display("ERR %s %s: expected %0h actual %0h", test, what, exp, act);
            err_cnt++;
        end
    endtask

    // ----------------------------------------------------------------------
    // Component request and R channel watch
    // ----------------------------------------------------------------------
    always @(posedge clk) begin : watch
        logic [AW-1:0] aligned;
        logic [AW-1:0] req_aligned;
        logic [1:0]    exp_resp;
        // First clock out of reset, idle and ready for AR
        if (rst_n && !reset_seen) begin
            reset_seen = 1'b1;
            check_value("after_reset", "arready", DW'(1), DW'(i_arready));
            check_value("after_reset", "rvalid", '0, DW'(i_rvalid));
            check_value("after_reset", "dv", '0, DW'(i_dv));
        end
        // Request accepted by the component on this edge
        if (rst_n && i_dv && !i_hld) begin
            if (req_q_idx >= q_name.size()) begin
                $display("Component request at address %0h while no burst is pending", i_addr);
                err_cnt++;
            end else begin
                if (req_beat == 0) begin
                    req_addr = q_addr[req_q_idx];
                end
                req_aligned = req_addr & ~AW'(DW / 8 - 1);
                check_value(q_name[req_q_idx], "request address", DW'(req_aligned),
                            DW'(i_addr));
                check_value(q_name[req_q_idx], "request id", DW'(q_id[req_q_idx]), DW'(i_id));
                check_value(q_name[req_q_idx], "request last",
                            DW'(req_beat == q_len[req_q_idx]), DW'(i_last));
                if (req_beat == q_len[req_q_idx]) begin
                    req_q_idx++;
                    req_beat = 0;
                end else begin
                    req_addr = step_addr(req_addr, q_size[req_q_idx], q_burst[req_q_idx],
                                         q_len[req_q_idx]);
                    req_beat++;
                end
            end
        end
        if (rst_n && i_rvalid && i_rready) begin
            if (q_name.size() == 0) begin
                $display("Unexpected R beat with rid %0h while no burst is outstanding", i_rid);
                err_cnt++;
            end else begin
                if (beat_idx == 0) begin
                    cur_addr = q_addr[0];
                end
                // Component sees the word address, returns it inverted
                aligned  = cur_addr & ~AW'(DW / 8 - 1);
                exp_resp = (aligned[11:8] == 4'he) ? 2'b10 : 2'b00;
                check_value(q_name[0], "rdata", DW'(~aligned), i_rdata);
                check_value(q_name[0], "rresp", DW'(exp_resp), DW'(i_rresp));
                check_value(q_name[0], "rid", DW'(q_id[0]), DW'(i_rid));
                check_value(q_name[0], "rlast", DW'(beat_idx == q_len[0]), DW'(i_rlast));
                beat_cnt++;
                if (beat_idx == q_len[0]) begin
                    check_value(q_name[0], "final address", DW'(q_final[0]), DW'(cur_addr));
                    q_name.delete(0);
                    q_id.delete(0);
                    q_len.delete(0);
                    q_size.delete(0);
                    q_burst.delete(0);
                    q_addr.delete(0);
                    q_final.delete(0);
                    // Head burst gone, request index shifts down with it
                    if (req_q_idx > 0) begin
                        req_q_idx--;
                    end
                    beat_idx = 0;
                    burst_cnt++;
                end else begin
                    cur_addr = step_addr(cur_addr, q_size[0], q_burst[0], q_len[0]);
                    beat_idx++;
                end
            end
        end
    end

endmodule

// File: tb_axi_rd_sub.sv
// Testbench top for axi_rd_sub; the component model assumes C_LAT of 2, data file read from the root
module tb_axi_rd_sub;

    localparam int AW         = 32;
    localparam int DW         = 32;
    localparam int IW         = 2;
    localparam int C_LAT      = 2;
    localparam int MAX_BURSTS = 64;

    logic          clk;
    logic          rst_n;
    logic          i_arvalid;
    logic          o_arready;
    logic [AW-1:0] i_araddr;
    logic [1:0]    i_arburst;
    logic [2:0]    i_arsize;
    logic [7:0]    i_arlen;
    logic [IW-1:0] i_arid;
    logic          o_rvalid;
    logic          i_rready;
    logic [DW-1:0] o_rdata;
    logic [1:0]    o_rresp;
    logic [IW-1:0] o_rid;
    logic          o_rlast;
    logic          o_dv;
    logic [AW-1:0] o_addr;
    logic [IW-1:0] o_id;
    logic          o_last;
    logic          i_hld;
    logic          i_err;
    logic [DW-1:0] i_rdata;

    // Bursts from the data file
    string         t_name  [MAX_BURSTS];
    logic [IW-1:0] t_id    [MAX_BURSTS];
    logic [7:0]    t_len   [MAX_BURSTS];
    logic [2:0]    t_size  [MAX_BURSTS];
    logic [1:0]    t_burst [MAX_BURSTS];
    logic [AW-1:0] t_addr  [MAX_BURSTS];
    logic [AW-1:0] t_final [MAX_BURSTS];
    int            n_bursts;
    int            total_beats;
    logic          load_ok;
    logic          load_done = 1'b0;
    int            seed;
    logic [31:0]   rnd;
    logic [AW-1:0] req_addr_q;

    axi_rd_sub #(
        .AW    (AW),
        .DW    (DW),
        .IW    (IW),
        .C_LAT (C_LAT)
    ) dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_arvalid (i_arvalid),
        .o_arready (o_arready),
        .i_araddr  (i_araddr),
        .i_arburst (i_arburst),
        .i_arsize  (i_arsize),
        .i_arlen   (i_arlen),
        .i_arid    (i_arid),
        .o_rvalid  (o_rvalid),
        .i_rready  (i_rready),
        .o_rdata   (o_rdata),
        .o_rresp   (o_rresp),
        .o_rid     (o_rid),
        .o_rlast   (o_rlast),
        .o_dv      (o_dv),
        .o_addr    (o_addr),
        .o_id      (o_id),
        .o_last    (o_last),
        .i_hld     (i_hld),
        .i_err     (i_err),
        .i_rdata   (i_rdata)
    );

    tb_axi_rd_checker #(
        .AW (AW),
        .DW (DW),
        .IW (IW)
    ) u_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_arready (o_arready),
        .i_dv      (o_dv),
        .i_hld     (i_hld),
        .i_addr    (o_addr),
        .i_id      (o_id),
        .i_last    (o_last),
        .i_rvalid  (o_rvalid),
        .i_rready  (i_rready),
        .i_rdata   (o_rdata),
        .i_rresp   (o_rresp),
        .i_rid     (o_rid),
        .i_rlast   (o_rlast)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // Data file and AR driver
    // ----------------------------------------------------------------------

    // Lines starting with # are column notes
    task automatic load_tests();
        int          fd;
        int          n;
        string       line;
        string       nm;
        logic [31:0] v_id;
        logic [31:0] v_len;
        logic [31:0] v_size;
        logic [31:0] v_burst;
        logic [31:0] v_addr;
        logic [31:0] v_final;
        n_bursts    = 0;
        total_beats = 0;
        fd = $fopen("axi_rd_testdata.txt", "r");
        load_ok = (fd != 0);
        if (fd == 0) begin
            $display("Cannot open axi_rd_testdata.txt");
        end else begin
            while (!$feof(fd) && n_bursts < MAX_BURSTS) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                n = $sscanf(line, "%s %h %h %h %h %h %h", nm, v_id, v_len, v_size,
                            v_burst, v_addr, v_final);
                if (n == 7) begin
                    t_name[n_bursts]  = nm;
                    t_id[n_bursts]    = v_id[IW-1:0];
                    t_len[n_bursts]   = v_len[7:0];
                    t_size[n_bursts]  = v_size[2:0];
                    t_burst[n_bursts] = v_burst[1:0];
                    t_addr[n_bursts]  = v_addr;
                    t_final[n_bursts] = v_final;
                    total_beats = total_beats + int'(v_len[7:0]) + 1;
                    n_bursts++;
                end
            end
            $fclose(fd);
            if (n_bursts == 0) begin
                $display("No bursts found in axi_rd_testdata.txt");
                load_ok = 1'b0;
            end
        end
    endtask

    // Holds arvalid until the clock where arready is sampled high
    task automatic send_burst(input int b);
        i_arvalid <= 1'b1;
        i_arid    <= t_id[b];
        i_arlen   <= t_len[b];
        i_arsize  <= t_size[b];
        i_arburst <= t_burst[b];
        i_araddr  <= t_addr[b];
        u_checker.add_burst(t_name[b], t_id[b], int'(t_len[b]), int'(t_size[b]),
                            int'(t_burst[b]), t_addr[b], t_final[b]);
        @(posedge clk);
        while (!o_arready) begin
            @(posedge clk);
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        i_arvalid = 1'b0;
        i_araddr  = '0;
        i_arburst = 2'b00;
        i_arsize  = 3'd0;
        i_arlen   = 8'd0;
        i_arid    = '0;
        load_tests();
        load_done = 1'b1;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        if (load_ok) begin
            // Back to back, the next AR is offered on the edge the last one is taken
            for (int b = 0; b < n_bursts; b++) begin
                send_burst(b);
            end
            i_arvalid <= 1'b0;
            while (u_checker.burst_cnt < n_bursts) begin
                @(posedge clk);
            end
            // Idle tail to catch stray beats
            repeat (20) @(posedge clk);
        end
        $display("Checked %0d bursts, %0d beats, %0d errors", u_checker.burst_cnt,
                 u_checker.beat_cnt, u_checker.err_cnt);
        if (load_ok && u_checker.err_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // ----------------------------------------------------------------------
    // Component model and random stalls
    // ----------------------------------------------------------------------

    // Address taken on the accepting edge, data out one edge later
    initial begin
        req_addr_q = '0;
        i_rdata    = '0;
        i_err      = 1'b0;
        forever begin
            @(posedge clk);
            req_addr_q <= o_addr;
            i_rdata    <= ~req_addr_q;
            i_err      <= (req_addr_q[11:8] == 4'he);
        end
    end

    // hld one clock in four, rready three in four
    initial begin
        seed     = 32'h5286;
        i_hld    = 1'b0;
        i_rready = 1'b0;
        forever begin
            @(posedge clk);
            rnd = $random(seed);
            i_hld    <= (rnd[1:0] == 2'b00);
            i_rready <= (rnd[3:2] != 2'b00);
        end
    end

    // Watchdog scaled by the beats in the file
    initial begin
        wait (load_done);
        repeat (200 * total_beats + 50) @(posedge clk);
        $display("Timeout after %0d cycles with %0d of %0d bursts done",
                 200 * total_beats + 50, u_checker.burst_cnt, n_bursts);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: axi_rd_testdata.txt
# name arid arlen arsize arburst araddr final_addr
# Hex fields, arburst 0 FIXED 1 INCR 2 WRAP, final_addr is the byte address of the last beat
incr_single   0 00 2 1 00001000 00001000
incr_len4     1 03 2 1 00002000 0000200c
incr_len16    2 0f 2 1 00003040 0000307c
incr_byte     3 05 0 1 00005001 00005006
wrap_len4     3 03 2 2 00006008 00006004
wrap_len8     0 07 2 2 00007014 00007010
wrap_half     1 03 1 2 0000800a 00008008
wrap_len16    2 0f 2 2 00009034 00009030
fixed_len4    0 03 2 0 0000a010 0000a010
fixed_byte    1 07 0 0 0000b003 0000b003
err_incr      1 03 2 1 00000ef8 00000f04
err_wrap      2 07 2 2 00010e10 00010e0c
err_fixed     3 01 2 0 00020e40 00020e40
b2b_id0       0 01 2 1 0000c000 0000c004

// File: axi_rd_sub.f
axi_rd_pkg.sv
axi_rd_addr_gen.sv
axi_rd_burst_ctrl.sv
axi_rd_ctx_pipe.sv
axi_rd_skid_buf.sv
axi_rd_resp_pipe.sv
axi_rd_sub.sv
tb_axi_rd_checker.sv
tb_axi_rd_sub.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the axi_rd_sub testbench, exit status follows the result line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_axi_rd_sub -f axi_rd_sub.f -o sim_axi_rd_sub
out=$(./obj_dir/sim_axi_rd_sub)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "TEST RESULT: PASS"
